//--- design/apb_split_pkg.sv
package apb_split_pkg;

    // Bus widths shared by the splitter and its completers
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int PROT_W = 3;

    // One APB address word
    typedef logic [ADDR_W-1:0] addr_t;

    // Read or write data word
    typedef logic [DATA_W-1:0] data_t;

    // Byte lane strobes, one per data byte
    typedef logic [STRB_W-1:0] strb_t;

    // PPROT encoding: privileged, non-secure, instruction
    typedef logic [PROT_W-1:0] prot_t;

endpackage

//--- design/apb_addr_decode.sv
`timescale 1ns/1ns

module apb_addr_decode #(
    parameter int                   N_SLAVES    = 8,
    parameter int                   WINDOW_BITS = 12,
    parameter apb_split_pkg::addr_t BASE_ADDR   = 32'hFEC00000
) (
    input  apb_split_pkg::addr_t m_paddr,
    output logic                 in_range,
    output logic [N_SLAVES-1:0]  sel_onehot
);

    localparam int IDX_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

    // One extra bit so a map ending at the top of the space still compares
    localparam logic [apb_split_pkg::ADDR_W:0] MAP_SIZE =
        (apb_split_pkg::ADDR_W + 1)'(N_SLAVES) << WINDOW_BITS;
    localparam logic [apb_split_pkg::ADDR_W:0] END_ADDR = {1'b0, BASE_ADDR} + MAP_SIZE;

    apb_split_pkg::addr_t offset;
    logic [IDX_W-1:0]     idx;

    assign offset = m_paddr - BASE_ADDR;

    // Window number sits just above the in-window byte offset
    assign idx = offset[WINDOW_BITS +: IDX_W];

    assign in_range = (m_paddr >= BASE_ADDR) && ({1'b0, m_paddr} < END_ADDR);

    always_comb begin
        for (int i = 0; i < N_SLAVES; i++) begin
            sel_onehot[i] = in_range && (idx == IDX_W'(i));
        end
    end

endmodule

//--- design/apb_split_ctrl.sv
`timescale 1ns/1ns

module apb_split_ctrl (
    input  logic pclk,
    input  logic presetn,
    input  logic m_psel,
    input  logic m_penable,
    input  logic in_range,
    input  logic sel_ready,
    output logic capture,
    output logic bus_active,
    output logic access_phase,
    output logic take_rsp,
    output logic err_local,
    output logic m_pready
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESP
    } split_state_t;

    split_state_t state;
    split_state_t state_next;
    logic         setup_seen;

    // Upstream setup phase is PSEL without PENABLE
    assign setup_seen = m_psel && !m_penable;

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (setup_seen) begin
                    // Out of range skips the downstream bus entirely
                    if (in_range) begin
                        state_next = SETUP;
                    end else begin
                        state_next = RESP;
                    end
                end
            end
            SETUP: begin
                state_next = ACCESS;
            end
            ACCESS: begin
                // Completer wait states hold here
                if (sel_ready) begin
                    state_next = RESP;
                end
            end
            RESP: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Pulses taken by the request and response registers
    assign capture  = (state == IDLE) && setup_seen;
    assign err_local = capture && !in_range;
    assign take_rsp = (state == ACCESS) && sel_ready;

    // Downstream phase levels
    assign bus_active   = (state == SETUP) || (state == ACCESS);
    assign access_phase = (state == ACCESS);

    // Upstream completion, one cycle per transfer
    assign m_pready = (state == RESP);

    // A completion never stretches into a second cycle
    assert property (@(posedge pclk) disable iff (!presetn)
        m_pready |=> !m_pready);

    // The requester must still be in its access phase when we complete
    assert property (@(posedge pclk) disable iff (!presetn)
        m_pready |-> (m_psel && m_penable));

endmodule

//--- design/apb_req_reg.sv
`timescale 1ns/1ns

module apb_req_reg #(
    parameter int N_SLAVES = 8
) (
    input  logic                 pclk,
    input  logic                 presetn,
    input  logic                 capture,
    input  logic                 bus_active,
    input  logic                 access_phase,
    input  logic [N_SLAVES-1:0]  sel_onehot,
    input  apb_split_pkg::addr_t m_paddr,
    input  logic                 m_pwrite,
    input  apb_split_pkg::data_t m_pwdata,
    input  apb_split_pkg::strb_t m_pstrb,
    input  apb_split_pkg::prot_t m_pprot,
    output logic [N_SLAVES-1:0]  s_psel,
    output logic                 s_penable,
    output apb_split_pkg::addr_t s_paddr,
    output logic                 s_pwrite,
    output apb_split_pkg::data_t s_pwdata,
    output apb_split_pkg::strb_t s_pstrb,
    output apb_split_pkg::prot_t s_pprot,
    output logic [N_SLAVES-1:0]  sel_hold
);

    // Broadcast fields, held from capture to the next capture
    always_ff @(posedge pclk) begin
        if (capture) begin
            s_paddr  <= m_paddr;
            s_pwrite <= m_pwrite;
            s_pwdata <= m_pwdata;
            s_pstrb  <= m_pstrb;
            s_pprot  <= m_pprot;
        end
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            sel_hold <= '0;
        end else if (capture) begin
            sel_hold <= sel_onehot;
        end
    end

    // Only the decoded completer sees PSEL, and only during setup and access
    assign s_psel    = sel_hold & {N_SLAVES{bus_active}};
    assign s_penable = access_phase;

    assert property (@(posedge pclk) disable iff (!presetn)
        $onehot0(s_psel));

    assert property (@(posedge pclk) disable iff (!presetn)
        s_penable |-> $stable(s_paddr));

    // no access phase without a selected completer
    assert property (@(posedge pclk) disable iff (!presetn)
        s_penable |-> (|s_psel));

endmodule

//--- design/apb_rsp_mux.sv
`timescale 1ns/1ns

module apb_rsp_mux #(
    parameter int N_SLAVES = 8
) (
    input  logic                 pclk,
    input  logic                 presetn,
    input  logic [N_SLAVES-1:0]  sel_hold,
    input  apb_split_pkg::data_t s_prdata [N_SLAVES],
    input  logic [N_SLAVES-1:0]  s_pslverr,
    input  logic [N_SLAVES-1:0]  s_pready,
    input  logic                 take_rsp,
    input  logic                 err_local,
    output logic                 sel_ready,
    output apb_split_pkg::data_t m_prdata,
    output logic                 m_pslverr
);

    apb_split_pkg::data_t sel_rdata;
    logic                 sel_err;

    // AND-OR select, sel_hold is one-hot
    always_comb begin
        sel_rdata = '0;
        for (int i = 0; i < N_SLAVES; i++) begin
            if (sel_hold[i]) begin
                sel_rdata = sel_rdata | s_prdata[i];
            end
        end
    end

    assign sel_ready = |(sel_hold & s_pready);
    assign sel_err   = |(sel_hold & s_pslverr);

    always_ff @(posedge pclk) begin
        if (take_rsp) begin
            m_prdata <= sel_rdata;
        end else if (err_local) begin
            m_prdata <= '0;
        end
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            m_pslverr <= 1'b0;
        end else if (take_rsp) begin
            m_pslverr <= sel_err;
        end else if (err_local) begin
            m_pslverr <= 1'b1;
        end
    end

    // A completer response is only taken from a single held completer
    assert property (@(posedge pclk) disable iff (!presetn)
        take_rsp |-> $onehot(sel_hold));

endmodule

//--- design/apb_split_top.sv
`timescale 1ns/1ns

module apb_split_top #(
    parameter int                   N_SLAVES    = 8,
    parameter int                   WINDOW_BITS = 12,
    parameter apb_split_pkg::addr_t BASE_ADDR   = 32'hFEC00000
) (
    input  logic                 pclk,
    input  logic                 presetn,

    // Upstream requester
    input  logic                 m_psel,
    input  logic                 m_penable,
    input  apb_split_pkg::addr_t m_paddr,
    input  logic                 m_pwrite,
    input  apb_split_pkg::data_t m_pwdata,
    input  apb_split_pkg::strb_t m_pstrb,
    input  apb_split_pkg::prot_t m_pprot,
    output apb_split_pkg::data_t m_prdata,
    output logic                 m_pslverr,
    output logic                 m_pready,

    // Downstream completers, shared bus with one PSEL each
    output logic [N_SLAVES-1:0]  s_psel,
    output logic                 s_penable,
    output apb_split_pkg::addr_t s_paddr,
    output logic                 s_pwrite,
    output apb_split_pkg::data_t s_pwdata,
    output apb_split_pkg::strb_t s_pstrb,
    output apb_split_pkg::prot_t s_pprot,
    input  apb_split_pkg::data_t s_prdata [N_SLAVES],
    input  logic [N_SLAVES-1:0]  s_pslverr,
    input  logic [N_SLAVES-1:0]  s_pready
);

    logic                capture;
    logic                bus_active;
    logic                access_phase;
    logic                take_rsp;
    logic                err_local;
    logic                in_range;
    logic                sel_ready;
    logic [N_SLAVES-1:0] sel_onehot;
    logic [N_SLAVES-1:0] sel_hold;

    apb_addr_decode #(
        .N_SLAVES    (N_SLAVES),
        .WINDOW_BITS (WINDOW_BITS),
        .BASE_ADDR   (BASE_ADDR)
    ) u_decode (
        .m_paddr    (m_paddr),
        .in_range   (in_range),
        .sel_onehot (sel_onehot)
    );

    apb_split_ctrl u_ctrl (
        .pclk         (pclk),
        .presetn      (presetn),
        .m_psel       (m_psel),
        .m_penable    (m_penable),
        .in_range     (in_range),
        .sel_ready    (sel_ready),
        .capture      (capture),
        .bus_active   (bus_active),
        .access_phase (access_phase),
        .take_rsp     (take_rsp),
        .err_local    (err_local),
        .m_pready     (m_pready)
    );

    apb_req_reg #(
        .N_SLAVES (N_SLAVES)
    ) u_req_reg (
        .pclk         (pclk),
        .presetn      (presetn),
        .capture      (capture),
        .bus_active   (bus_active),
        .access_phase (access_phase),
        .sel_onehot   (sel_onehot),
        .m_paddr      (m_paddr),
        .m_pwrite     (m_pwrite),
        .m_pwdata     (m_pwdata),
        .m_pstrb      (m_pstrb),
        .m_pprot      (m_pprot),
        .s_psel       (s_psel),
        .s_penable    (s_penable),
        .s_paddr      (s_paddr),
        .s_pwrite     (s_pwrite),
        .s_pwdata     (s_pwdata),
        .s_pstrb      (s_pstrb),
        .s_pprot      (s_pprot),
        .sel_hold     (sel_hold)
    );

    apb_rsp_mux #(
        .N_SLAVES (N_SLAVES)
    ) u_rsp_mux (
        .pclk      (pclk),
        .presetn   (presetn),
        .sel_hold  (sel_hold),
        .s_prdata  (s_prdata),
        .s_pslverr (s_pslverr),
        .s_pready  (s_pready),
        .take_rsp  (take_rsp),
        .err_local (err_local),
        .sel_ready (sel_ready),
        .m_prdata  (m_prdata),
        .m_pslverr (m_pslverr)
    );

endmodule

//--- test/apb_split_tb.sv
`timescale 1ns/1ns

module apb_split_tb;

    localparam int                   N_SLAVES    = 8;
    localparam int                   WINDOW_BITS = 12;
    localparam apb_split_pkg::addr_t BASE_ADDR   = 32'hFEC00000;
    localparam apb_split_pkg::addr_t MAP_END     = BASE_ADDR + (N_SLAVES << WINDOW_BITS);
    localparam int                   TIMEOUT     = 20;

    logic                 pclk;
    logic                 presetn;
    logic                 m_psel;
    logic                 m_penable;
    apb_split_pkg::addr_t m_paddr;
    logic                 m_pwrite;
    apb_split_pkg::data_t m_pwdata;
    apb_split_pkg::strb_t m_pstrb;
    apb_split_pkg::prot_t m_pprot;
    apb_split_pkg::data_t m_prdata;
    logic                 m_pslverr;
    logic                 m_pready;
    logic [N_SLAVES-1:0]  s_psel;
    logic                 s_penable;
    apb_split_pkg::addr_t s_paddr;
    logic                 s_pwrite;
    apb_split_pkg::data_t s_pwdata;
    apb_split_pkg::strb_t s_pstrb;
    apb_split_pkg::prot_t s_pprot;
    apb_split_pkg::data_t s_prdata [N_SLAVES];
    logic [N_SLAVES-1:0]  s_pslverr;
    logic [N_SLAVES-1:0]  s_pready;

    // Completer models
    apb_split_pkg::data_t mem [N_SLAVES][16];
    logic [1:0]           wait_cnt [N_SLAVES];
    int                   last_wait;
    logic [31:0]          lfsr;

    // Expected downstream view of the current transfer
    logic [N_SLAVES-1:0]  exp_sel;
    apb_split_pkg::addr_t cur_addr;
    logic                 cur_write;
    apb_split_pkg::prot_t cur_prot;
    logic                 sel_seen;

    int                   errors;
    int                   checks;
    int                   xfer_count;
    logic                 timed_out;
    int                   fd;
    int                   n;
    string                line;
    byte                  op;
    apb_split_pkg::addr_t f_addr;
    apb_split_pkg::data_t f_wdata;
    apb_split_pkg::strb_t f_strb;
    apb_split_pkg::data_t f_rdata;
    logic                 f_err;

    apb_split_top #(
        .N_SLAVES    (N_SLAVES),
        .WINDOW_BITS (WINDOW_BITS),
        .BASE_ADDR   (BASE_ADDR)
    ) dut_i (
        .pclk      (pclk),
        .presetn   (presetn),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_paddr   (m_paddr),
        .m_pwrite  (m_pwrite),
        .m_pwdata  (m_pwdata),
        .m_pstrb   (m_pstrb),
        .m_pprot   (m_pprot),
        .m_prdata  (m_prdata),
        .m_pslverr (m_pslverr),
        .m_pready  (m_pready),
        .s_psel    (s_psel),
        .s_penable (s_penable),
        .s_paddr   (s_paddr),
        .s_pwrite  (s_pwrite),
        .s_pwdata  (s_pwdata),
        .s_pstrb   (s_pstrb),
        .s_pprot   (s_pprot),
        .s_prdata  (s_prdata),
        .s_pslverr (s_pslverr),
        .s_pready  (s_pready)
    );

    initial begin
        pclk = 1'b0;
    end

    always #20 pclk = ~pclk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Completer outputs follow the shared bus
    always_comb begin
        for (int i = 0; i < N_SLAVES; i++) begin
            s_pready[i]  = s_psel[i] && s_penable && (wait_cnt[i] == 2'd0);
            s_pslverr[i] = s_psel[i] && (s_paddr[11:8] == 4'hF);
            s_prdata[i]  = s_psel[i] ? mem[i][s_paddr[5:2]] : '0;
        end
    end

    always @(posedge pclk) begin
        logic [1:0]           w;
        apb_split_pkg::data_t merged;
        for (int i = 0; i < N_SLAVES; i++) begin
            if (s_psel[i] && !s_penable) begin
                // Two LFSR steps give a wait count of 0 to 3
                lfsr = lfsr_step(lfsr);
                w[0] = lfsr[0];
                lfsr = lfsr_step(lfsr);
                w[1] = lfsr[0];
                wait_cnt[i] <= w;
                last_wait   <= w;
            end else if (s_psel[i] && s_penable) begin
                if (wait_cnt[i] != 2'd0) begin
                    wait_cnt[i] <= wait_cnt[i] - 2'd1;
                end else if (s_pwrite && s_paddr[11:8] != 4'hF) begin
                    merged = mem[i][s_paddr[5:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (s_pstrb[b]) begin
                            merged[b*8 +: 8] = s_pwdata[b*8 +: 8];
                        end
                    end
                    mem[i][s_paddr[5:2]] <= merged;
                end
            end
        end
    end

    // Downstream bus monitor
    always @(negedge pclk) begin
        if (presetn && (|s_psel)) begin
            sel_seen = 1'b1;
            check_equal("s_psel", 32'(s_psel), 32'(exp_sel));
            check_equal("s_paddr", s_paddr, cur_addr);
            check_equal("s_pwrite", 32'(s_pwrite), 32'(cur_write));
            check_equal("s_pprot", 32'(s_pprot), 32'(cur_prot));
        end
    end

    // Runs one transfer, starting and ending right after a falling edge
    task automatic run_transfer(input byte op_c, input apb_split_pkg::addr_t addr,
                                input apb_split_pkg::data_t wdata,
                                input apb_split_pkg::strb_t strb,
                                input apb_split_pkg::data_t exp_rdata, input logic exp_err);
        int   cycles;
        int   exp_lat;
        logic in_rng;
        in_rng    = (addr >= BASE_ADDR) && (addr < MAP_END);
        exp_sel   = in_rng ? N_SLAVES'(1) << ((addr - BASE_ADDR) >> WINDOW_BITS) : '0;
        cur_addr  = addr;
        cur_write = (op_c == "W");
        cur_prot  = 3'(xfer_count);
        sel_seen  = 1'b0;
        xfer_count++;
        m_psel    = 1'b1;
        m_penable = 1'b0;
        m_paddr   = addr;
        m_pwrite  = cur_write;
        m_pwdata  = wdata;
        m_pstrb   = cur_write ? strb : '0;
        m_pprot   = cur_prot;
        @(posedge pclk);
        @(negedge pclk);
        m_penable = 1'b1;
        cycles = 1;
        while (!m_pready && cycles < TIMEOUT) begin
            @(negedge pclk);
            cycles++;
        end
        if (!m_pready) begin
            $display("Timeout: no m_pready for address %h after %0d cycles", addr, cycles);
            errors++;
            timed_out = 1'b1;
        end else begin
            exp_lat = in_rng ? 3 + last_wait : 1;
            check_equal("m_pready latency", cycles, exp_lat);
            check_equal("m_pslverr", 32'(m_pslverr), 32'(exp_err));
            if (!cur_write || !in_rng) begin
                check_equal("m_prdata", m_prdata, in_rng ? exp_rdata : '0);
            end
            if (in_rng) begin
                checks++;
                assert (sel_seen) else begin
                    $display("No completer select rose for address %h", addr);
                    errors++;
                end
            end
            @(posedge pclk);
            @(negedge pclk);
            // Completion lasts a single cycle
            check_equal("m_pready", 32'(m_pready), 32'd0);
            m_psel    = 1'b0;
            m_penable = 1'b0;
            @(negedge pclk);
        end
    endtask

    initial begin
        presetn    = 1'b0;
        m_psel     = 1'b0;
        m_penable  = 1'b0;
        m_paddr    = '0;
        m_pwrite   = 1'b0;
        m_pwdata   = '0;
        m_pstrb    = '0;
        m_pprot    = '0;
        errors     = 0;
        checks     = 0;
        xfer_count = 0;
        timed_out  = 1'b0;
        last_wait  = 0;
        exp_sel    = '0;
        sel_seen   = 1'b0;
        lfsr       = 32'h1313;
        for (int i = 0; i < N_SLAVES; i++) begin
            wait_cnt[i] = 2'd0;
            for (int j = 0; j < 16; j++) begin
                mem[i][j] = 32'hC0DE0000 | (i << 8) | j;
            end
        end
        repeat (2) @(negedge pclk);
        check_equal("m_pready", 32'(m_pready), 32'd0);
        check_equal("s_penable", 32'(s_penable), 32'd0);
        check_equal("s_psel", 32'(s_psel), 32'd0);
        repeat (2) @(negedge pclk);
        presetn = 1'b1;
        @(negedge pclk);
        check_equal("m_pready", 32'(m_pready), 32'd0);
        check_equal("s_psel", 32'(s_psel), 32'd0);
        fd = $fopen("test/apb_split_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/apb_split_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %h", op, f_addr, f_wdata, f_strb,
                                f_rdata, f_err);
                    if (n == 6) begin
                        run_transfer(op, f_addr, f_wdata, f_strb, f_rdata, f_err);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Transfers: %0d, checks: %0d, errors: %0d", xfer_count, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- test/apb_split_input.txt
# Columns (hex): op address write_data strobes expected_read_data expected_error
# Read data is compared on R lines only
W FEC00010 11223344 F 00000000 0
R FEC00010 00000000 0 11223344 0
W FEC01020 AABBCCDD F 00000000 0
W FEC01020 00000099 1 00000000 0
R FEC01020 00000000 0 AABBCC99 0
W FEC02004 12345678 F 00000000 0
W FEC02004 FFEEDDCC 6 00000000 0
R FEC02004 00000000 0 12EEDD78 0
W FEC0303C DEADBEEF F 00000000 0
R FEC0303C 00000000 0 DEADBEEF 0
W FEC04008 CAFEF00D F 00000000 0
W FEC04008 5555AAAA 8 00000000 0
R FEC04008 00000000 0 55FEF00D 0
W FEC05000 0BADC0DE F 00000000 0
R FEC05000 00000000 0 0BADC0DE 0
W FEC06014 76543210 F 00000000 0
W FEC06014 0000A500 2 00000000 0
R FEC06014 00000000 0 7654A510 0
W FEC0702C 89ABCDEF F 00000000 0
R FEC0702C 00000000 0 89ABCDEF 0
W FEC05F00 FFFFFFFF F 00000000 1
R FEC05000 00000000 0 0BADC0DE 0
R FEC03F3C 00000000 0 DEADBEEF 1
R FEBFFFFC 00000000 0 00000000 1
W FEC08000 12345678 F 00000000 1
R FEC08000 00000000 0 00000000 1
W FFFFFFFC 11111111 F 00000000 1
R 00000000 00000000 0 00000000 1
R FEC00010 00000000 0 11223344 0

//--- src.f
design/apb_split_pkg.sv
design/apb_addr_decode.sv
design/apb_split_ctrl.sv
design/apb_req_reg.sv
design/apb_rsp_mux.sv
design/apb_split_top.sv
test/apb_split_tb.sv
